// File: common/lsu_defines.svh
//////////////////////////////////////////////////////////////////////
// Width and depth macros for the load/store unit and its DTIM
//////////////////////////////////////////////////////////////////////

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data path
`define LSU_XLEN 32            // Word width in bits
`define LSU_BYTES 4            // Byte lanes per word

// Data tightly integrated memory
`define LSU_DTIM_WORDS 256     // Words in the DTIM
`define LSU_DTIM_ADR_BITS 8    // Word index width

`endif

// File: common/isaPkg.sv
//////////////////////////////////////////////////////////////////////
// RISC-V encodings for memory operations
// Access sizes follow funct3, AMO functions follow funct7[6:2]
//////////////////////////////////////////////////////////////////////

package isaPkg;

  // Load/store size from funct3
  typedef enum logic [2:0] {
    sizeByte  = 3'b000,   // lb / sb
    sizeHalf  = 3'b001,   // lh / sh
    sizeWord  = 3'b010,   // lw / sw, all AMOs
    sizeByteU = 3'b100,   // lbu
    sizeHalfU = 3'b101    // lhu
  } memSize_e;

  // Atomic function from the upper funct7 bits
  typedef enum logic [4:0] {
    amoAdd  = 5'b00000,
    amoSwap = 5'b00001,
    amoLr   = 5'b00010,   // Load reserved
    amoSc   = 5'b00011,   // Store conditional
    amoXor  = 5'b00100,
    amoOr   = 5'b01000,
    amoAnd  = 5'b01100,
    amoMin  = 5'b10000,
    amoMax  = 5'b10100,
    amoMinu = 5'b11000,
    amoMaxu = 5'b11100
  } amoOp_e;

endpackage

// File: common/lsuPkg.sv
//////////////////////////////////////////////////////////////////////
// Request, fault and DTIM write types of the load/store unit
//////////////////////////////////////////////////////////////////////

`include "lsu_defines.svh"

package lsuPkg;

  // Memory read/write control, amo reads and writes the same word
  typedef enum logic [1:0] {
    rwNone  = 2'b00,
    rwWrite = 2'b01,
    rwRead  = 2'b10,
    rwAmo   = 2'b11
  } memRw_e;

  // One memory request as it moves from E to M
  typedef struct packed {
    memRw_e               rw;
    isaPkg::memSize_e     size;
    isaPkg::amoOp_e       amoOp;       // Only meaningful with atomic set
    logic                 atomic;      // LR, SC or AMO
    logic [`LSU_XLEN-1:0] adr;         // Byte address
    logic [`LSU_XLEN-1:0] writeData;   // Store data or AMO operand
  } memReq_t;

  typedef struct packed {
    logic loadMisaligned;
    logic storeMisaligned;             // Store, SC or AMO
  } faults_t;

  // DTIM write port
  typedef struct packed {
    logic                          we;
    logic [`LSU_DTIM_ADR_BITS-1:0] index;
    logic [`LSU_BYTES-1:0]         mask;
    logic [`LSU_XLEN-1:0]          data;
  } dtimWr_t;

endpackage

// File: hdl/amoAlu.sv
//////////////////////////////////////////////////////////////////////
// AMO arithmetic on the old memory word and the register operand
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module amoAlu (
  input  isaPkg::amoOp_e       op,
  input  logic [`LSU_XLEN-1:0] memWord,    // Old value at the address
  input  logic [`LSU_XLEN-1:0] operand,    // rs2
  output logic [`LSU_XLEN-1:0] result      // Value written back
);

  logic lessSigned;
  logic lessUnsigned;

  // Shared comparators for min and max
  assign lessSigned   = $signed(memWord) < $signed(operand);
  assign lessUnsigned = memWord < operand;

  always_comb begin
    case (op)
      isaPkg::amoAdd:  result = memWord + operand;
      isaPkg::amoXor:  result = memWord ^ operand;
      isaPkg::amoOr:   result = memWord | operand;
      isaPkg::amoAnd:  result = memWord & operand;
      isaPkg::amoMin:  result = lessSigned ? memWord : operand;
      isaPkg::amoMax:  result = lessSigned ? operand : memWord;
      isaPkg::amoMinu: result = lessUnsigned ? memWord : operand;
      isaPkg::amoMaxu: result = lessUnsigned ? operand : memWord;
      isaPkg::amoSwap: result = operand;
      default:         result = operand;     // LR and SC carry no arithmetic
    endcase
  end

endmodule

// File: hdl/dtim.sv
//////////////////////////////////////////////////////////////////////
// Data TIM with byte write enables
// Writes land at the clock edge, reads are combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module dtim (
  input  logic                          clk,
  input  lsuPkg::dtimWr_t               dtimWr,
  input  logic [`LSU_DTIM_ADR_BITS-1:0] rdIndex,
  output logic [`LSU_XLEN-1:0]          rdWord
);

  logic [`LSU_XLEN-1:0] memArray [0:`LSU_DTIM_WORDS-1];

  always_ff @(posedge clk) begin
    if (dtimWr.we) begin
      for (int b = 0; b < `LSU_BYTES; b++) begin
        if (dtimWr.mask[b]) begin
          memArray[dtimWr.index][8*b +: 8] <= dtimWr.data[8*b +: 8];   // One lane
        end
      end
    end
  end

  assign rdWord = memArray[rdIndex];   // Same-cycle read

endmodule

// File: subword/storeFormat.sv
//////////////////////////////////////////////////////////////////////
// Store formatting with lane replication, byte mask and endian swap
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module storeFormat (
  input  isaPkg::memSize_e      size,
  input  logic [1:0]            adrOffset,   // Byte within the word
  input  logic                  bigEndian,
  input  logic [`LSU_XLEN-1:0]  writeData,
  output logic [`LSU_XLEN-1:0]  stWord,      // Memory byte order
  output logic [`LSU_BYTES-1:0] byteMask
);

  logic [`LSU_XLEN-1:0] replWord;

  // Copy the byte or half into every lane so the mask alone picks the target
  always_comb begin
    case (size)
      isaPkg::sizeByte, isaPkg::sizeByteU: replWord = {`LSU_BYTES{writeData[7:0]}};
      isaPkg::sizeHalf, isaPkg::sizeHalfU: replWord = {(`LSU_BYTES/2){writeData[15:0]}};
      default:                             replWord = writeData;
    endcase
  end

  // Whole-word byte reversal in big-endian mode
  always_comb begin
    for (int i = 0; i < `LSU_BYTES; i++) begin
      stWord[8*i +: 8] = bigEndian ? replWord[8*(`LSU_BYTES-1-i) +: 8] : replWord[8*i +: 8];
    end
  end

  always_comb begin
    byteMask = '0;
    case (size)
      isaPkg::sizeByte, isaPkg::sizeByteU: byteMask[adrOffset] = 1'b1;
      isaPkg::sizeHalf, isaPkg::sizeHalfU: byteMask[{adrOffset[1], 1'b0} +: 2] = 2'b11;
      default:                             byteMask = '1;   // Word
    endcase
  end

endmodule

// File: subword/loadExtract.sv
//////////////////////////////////////////////////////////////////////
// Load extraction with endian swap, lane select and extension
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module loadExtract (
  input  logic [`LSU_XLEN-1:0] rdWord,      // Raw DTIM word
  input  isaPkg::memSize_e     size,
  input  logic [1:0]           adrOffset,
  input  logic                 bigEndian,
  output logic [`LSU_XLEN-1:0] readData
);

  logic [`LSU_XLEN-1:0] leWord;   // Register byte order
  logic [1:0]           lane;
  logic [7:0]           byteVal;
  logic [15:0]          halfVal;

  always_comb begin
    for (int i = 0; i < `LSU_BYTES; i++) begin
      leWord[8*i +: 8] = bigEndian ? rdWord[8*(`LSU_BYTES-1-i) +: 8] : rdWord[8*i +: 8];
    end
  end

  // After the swap, big-endian lanes sit mirrored
  assign lane    = adrOffset ^ {2{bigEndian}};
  assign byteVal = leWord[8*lane +: 8];
  assign halfVal = leWord[16*lane[1] +: 16];

  always_comb begin
    case (size)
      isaPkg::sizeByte:  readData = {{(`LSU_XLEN-8){byteVal[7]}}, byteVal};     // Sign
      isaPkg::sizeHalf:  readData = {{(`LSU_XLEN-16){halfVal[15]}}, halfVal};
      isaPkg::sizeByteU: readData = {{(`LSU_XLEN-8){1'b0}}, byteVal};           // Zero
      isaPkg::sizeHalfU: readData = {{(`LSU_XLEN-16){1'b0}}, halfVal};
      default:           readData = leWord;
    endcase
  end

endmodule

// File: hdl/lsuCtrl.sv
//////////////////////////////////////////////////////////////////////
// LSU control with E/M and M/W registers, misalignment faults,
// LR/SC reservation and DTIM write gating
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsuCtrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  logic                  flush,
  input  lsuPkg::memReq_t       reqE,
  output lsuPkg::memReq_t       reqM,
  input  logic [`LSU_XLEN-1:0]  readDataM,
  input  logic [`LSU_XLEN-1:0]  amoResultM,   // Already in memory byte order
  input  logic [`LSU_XLEN-1:0]  stWordM,
  input  logic [`LSU_BYTES-1:0] byteMaskM,
  output lsuPkg::faults_t       faultsM,
  output lsuPkg::dtimWr_t       dtimWr,
  output logic [`LSU_XLEN-1:0]  readDataW,
  output logic                  squashScW
);

  logic                          misalignedM;
  logic                          faultM;      // Either fault bit
  logic                          isLrM, isScM, isAmoM;
  logic                          scOkM;       // Reservation matches this SC
  logic                          loadM;       // Result goes to W
  logic [`LSU_DTIM_ADR_BITS-1:0] indexM;
  logic                          resValid;
  logic [`LSU_DTIM_ADR_BITS-1:0] resIndex;

  //////////////////////////////////////////////////////////////////////
  // E to M request register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      reqM <= '0;                                 // rw none
    end else if (!stall) begin
      reqM <= flush ? lsuPkg::memReq_t'('0) : reqE;
    end
  end

  assign indexM = reqM.adr[`LSU_DTIM_ADR_BITS+1:2];

  // Address must be a multiple of the access size
  always_comb begin
    case (reqM.size)
      isaPkg::sizeHalf, isaPkg::sizeHalfU: misalignedM = reqM.adr[0];
      isaPkg::sizeWord:                    misalignedM = |reqM.adr[1:0];
      default:                             misalignedM = 1'b0;
    endcase
  end

  assign faultsM.loadMisaligned  = misalignedM & (reqM.rw == lsuPkg::rwRead);
  assign faultsM.storeMisaligned = misalignedM & reqM.rw[0];   // Write or AMO
  assign faultM = faultsM.loadMisaligned | faultsM.storeMisaligned;

  assign isAmoM = reqM.rw == lsuPkg::rwAmo;
  assign isLrM  = (reqM.rw == lsuPkg::rwRead) & reqM.atomic & (reqM.amoOp == isaPkg::amoLr);
  assign isScM  = (reqM.rw == lsuPkg::rwWrite) & reqM.atomic & (reqM.amoOp == isaPkg::amoSc);
  assign scOkM  = resValid & (resIndex == indexM);
  assign loadM  = (reqM.rw != lsuPkg::rwNone) & ~faultM;

  // DTIM write, a failing SC writes nothing
  assign dtimWr.we    = ~stall & ~faultM &
                        (((reqM.rw == lsuPkg::rwWrite) & ~(isScM & ~scOkM)) | isAmoM);
  assign dtimWr.index = indexM;
  assign dtimWr.mask  = isAmoM ? '1 : byteMaskM;   // AMOs are full words
  assign dtimWr.data  = isAmoM ? amoResultM : stWordM;

  //////////////////////////////////////////////////////////////////////
  // LR reservation
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      resValid <= 1'b0;
      resIndex <= '0;
    end else if (!stall && !faultM) begin
      if (isLrM) begin
        resValid <= 1'b1;
        resIndex <= indexM;
      end else if (isScM) begin
        resValid <= 1'b0;                         // Any SC ends the reservation
      end
    end
  end

  // M to W, SC returns the old word
  always_ff @(posedge clk) begin
    if (rst) begin
      readDataW <= '0;
      squashScW <= 1'b0;
    end else if (!stall) begin
      readDataW <= loadM ? readDataM : '0;
      squashScW <= isScM & ~scOkM & ~faultM;
    end
  end

endmodule

// File: hdl/lsu.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit top level on a single-cycle DTIM
// Control block plus store, AMO, memory and load datapath blocks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,      // Holds every register
  input  logic                 flush,      // Drops the request in E
  input  logic                 bigEndian,
  input  lsuPkg::memReq_t      reqE,
  output lsuPkg::faults_t      faultsM,
  output logic [`LSU_XLEN-1:0] readDataW,
  output logic                 squashScW   // SC failed
);

  lsuPkg::memReq_t      reqM;
  lsuPkg::dtimWr_t      dtimWr;
  logic [`LSU_XLEN-1:0] rdWordM;           // Raw DTIM word
  logic [`LSU_XLEN-1:0] readDataM;         // Extended load data
  logic [`LSU_XLEN-1:0] amoResultM;        // AMO result in register order
  logic [`LSU_XLEN-1:0] amoWordM;          // AMO result in memory order
  logic [`LSU_XLEN-1:0] stWordM;
  logic [`LSU_BYTES-1:0] byteMaskM;

  lsuCtrl ctrl (.clk, .rst, .stall, .flush, .reqE, .reqM, .readDataM,
    .amoResultM(amoWordM), .stWordM, .byteMaskM, .faultsM, .dtimWr, .readDataW, .squashScW);

  dtim mem (.clk, .dtimWr, .rdIndex(reqM.adr[`LSU_DTIM_ADR_BITS+1:2]), .rdWord(rdWordM));

  loadExtract ldExt (.rdWord(rdWordM), .size(reqM.size), .adrOffset(reqM.adr[1:0]),
    .bigEndian, .readData(readDataM));

  // Old word comes back through the load path, so it is already in register order
  amoAlu amo (.op(reqM.amoOp), .memWord(readDataM), .operand(reqM.writeData),
    .result(amoResultM));

  storeFormat stFmt (.size(reqM.size), .adrOffset(reqM.adr[1:0]), .bigEndian,
    .writeData(reqM.writeData), .stWord(stWordM), .byteMask(byteMaskM));

  // AMO result back to memory byte order, always a full aligned word
  storeFormat amoFmt (.size(isaPkg::sizeWord), .adrOffset(2'b00), .bigEndian,
    .writeData(amoResultM), .stWord(amoWordM), .byteMask());

endmodule

// File: verification/lsu_checker.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the LSU top-level ports, bound into lsu
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_checker (
  input logic                 clk,
  input logic                 rst,
  input logic                 stall,
  input lsuPkg::faults_t      faultsM,
  input logic [`LSU_XLEN-1:0] readDataW,
  input logic                 squashScW
);

  // W outputs come out of reset cleared
  resetClear: assert property (@(posedge clk) rst |=> (readDataW == '0 && !squashScW))
    else $error("W outputs not cleared after reset");

  // A request is either a load or a store, never both
  oneFault: assert property (@(posedge clk) disable iff (rst)
    !(faultsM.loadMisaligned && faultsM.storeMisaligned))
    else $error("Both misalignment fault bits set");

  stallHold: assert property (@(posedge clk) disable iff (rst)
    stall |=> ($stable(readDataW) && $stable(squashScW) && $stable(faultsM)))
    else $error("Output changed while stall was held");

endmodule

bind lsu lsu_checker chk (.clk, .rst, .stall, .faultsM, .readDataW, .squashScW);

// File: verification/tb_lsu.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the LSU with byte-array reference model
// Runs directed and random requests and prints a summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu;

  typedef struct packed {
    logic                 valid;
    logic [`LSU_XLEN-1:0] data;
    logic                 squash;
    lsuPkg::faults_t      faults;
  } expect_t;

  localparam int RAND_PAIRS = 150;
  localparam int AMO_ROUNDS = 3;
  localparam int MAX_REQ    = `LSU_DTIM_WORDS + 4*RAND_PAIRS + 18*AMO_ROUNDS + 120;
  localparam int TIMEOUT_NS = (MAX_REQ*3 + 16 + 200) * 8;   // 3 cycles per request plus margin

  logic clk = 1'b0, rst = 1'b1, stall = 1'b0, flush = 1'b0, bigEndian = 1'b0;
  lsuPkg::memReq_t      reqE = '0;
  lsuPkg::faults_t      faultsM;
  logic [`LSU_XLEN-1:0] readDataW;
  logic                 squashScW;

  logic [7:0] refMem [0:4*`LSU_DTIM_WORDS-1];   // Byte-addressed model
  logic       resValid = 1'b0;
  int         resIdx = 0;
  expect_t    eStage = '0, mStage = '0, wStage = '0;
  string      eName = "", mName = "", wName = "";
  int         seed = 93, errCount = 0, checkCount = 0, testCount = 0, failTests = 0;
  int         testErrs = 0;

  lsu u_dut (.clk, .rst, .stall, .flush, .bigEndian, .reqE, .faultsM, .readDataW, .squashScW);

  always #4 clk = ~clk;

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic int sizeBytes(isaPkg::memSize_e s);
    case (s)
      isaPkg::sizeHalf, isaPkg::sizeHalfU: return 2;
      isaPkg::sizeWord:                    return 4;
      default:                             return 1;
    endcase
  endfunction

  function automatic isaPkg::memSize_e sizeFromIndex(int k);
    case (k)
      0: return isaPkg::sizeByte;
      1: return isaPkg::sizeHalf;
      3: return isaPkg::sizeByteU;
      4: return isaPkg::sizeHalfU;
      default: return isaPkg::sizeWord;
    endcase
  endfunction

  // Byte at a is the MSB in big-endian mode, the LSB otherwise
  function automatic logic [31:0] readRef(int a, isaPkg::memSize_e s);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < sizeBytes(s); k++) begin
      if (bigEndian) v = (v << 8) | 32'(refMem[a+k]);
      else v[8*k +: 8] = refMem[a+k];
    end
    case (s)
      isaPkg::sizeByte: return {{24{v[7]}}, v[7:0]};
      isaPkg::sizeHalf: return {{16{v[15]}}, v[15:0]};
      default:          return v;                      // Unsigned and word
    endcase
  endfunction

  function automatic void writeRef(int a, isaPkg::memSize_e s, logic [31:0] d);
    int n;
    n = sizeBytes(s);
    for (int k = 0; k < n; k++) begin
      refMem[a+k] = bigEndian ? d[8*(n-1-k) +: 8] : d[8*k +: 8];
    end
  endfunction

  function automatic logic [31:0] amoRef(isaPkg::amoOp_e op, logic [31:0] m, logic [31:0] x);
    case (op)
      isaPkg::amoAdd:  return m + x;
      isaPkg::amoXor:  return m ^ x;
      isaPkg::amoOr:   return m | x;
      isaPkg::amoAnd:  return m & x;
      isaPkg::amoMin:  return ($signed(m) <= $signed(x)) ? m : x;
      isaPkg::amoMax:  return ($signed(m) >= $signed(x)) ? m : x;
      isaPkg::amoMinu: return (m <= x) ? m : x;
      isaPkg::amoMaxu: return (m >= x) ? m : x;
      default:         return x;                       // Swap
    endcase
  endfunction

  // Predicts one request and updates the model state
  function automatic expect_t refModel(lsuPkg::memReq_t r);
    expect_t e;
    int      a;
    logic    ok;
    e = '0;
    e.valid = 1'b1;
    a = int'(r.adr[9:0]);
    if (r.rw == lsuPkg::rwNone) return e;
    if ((a % sizeBytes(r.size)) != 0) begin
      if (r.rw == lsuPkg::rwRead) e.faults.loadMisaligned = 1'b1;
      else e.faults.storeMisaligned = 1'b1;
      return e;                                        // No side effects
    end
    e.data = readRef(a, r.size);                       // Old contents, also for stores
    if (r.rw == lsuPkg::rwRead && r.atomic && r.amoOp == isaPkg::amoLr) begin
      resValid = 1'b1;
      resIdx = a / 4;
    end else if (r.rw == lsuPkg::rwWrite && r.atomic && r.amoOp == isaPkg::amoSc) begin
      ok = resValid && (resIdx == a / 4);
      resValid = 1'b0;
      e.squash = !ok;
      if (ok) writeRef(a, r.size, r.writeData);
    end else if (r.rw == lsuPkg::rwWrite) begin
      writeRef(a, r.size, r.writeData);
    end else if (r.rw == lsuPkg::rwAmo) begin
      writeRef(a, isaPkg::sizeWord, amoRef(r.amoOp, e.data, r.writeData));
    end
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and compare process
  //////////////////////////////////////////////////////////////////////
  task automatic checkData(string nm, logic [`LSU_XLEN-1:0] exp, logic [`LSU_XLEN-1:0] act);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      $display("error %s: expected %h, actual %h", nm, exp, act);
    end
  endtask

  task automatic checkFaults(string nm, lsuPkg::faults_t exp, lsuPkg::faults_t act);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      $display("error %s faults: expected %b, actual %b", nm, exp, act);
    end
  endtask

  task automatic checkSquash(string nm, logic exp, logic act);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      $display("error %s squash: expected %b, actual %b", nm, exp, act);
    end
  endtask

  // Mirror of the E/M/W pipeline
  always @(posedge clk) begin
    if (rst) begin
      mStage = '0;
      wStage = '0;
    end else if (!stall) begin
      wStage = mStage;
      wName  = mName;
      mStage = eStage;
      mName  = eName;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (mStage.valid) checkFaults(mName, mStage.faults, faultsM);
      if (wStage.valid) begin
        checkData(wName, wStage.data, readDataW);
        checkSquash(wName, wStage.squash, squashScW);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  function automatic lsuPkg::memReq_t makeReq(lsuPkg::memRw_e rw, isaPkg::memSize_e s,
      isaPkg::amoOp_e op, logic atomic, int adr, logic [31:0] d);
    lsuPkg::memReq_t r;
    r.rw = rw;
    r.size = s;
    r.amoOp = op;
    r.atomic = atomic;
    r.adr = 32'(adr);
    r.writeData = d;
    return r;
  endfunction

  task automatic issue(lsuPkg::memReq_t r, string nm, bit doFlush = 1'b0);
    @(posedge clk);
    #1;
    reqE  = r;
    flush = doFlush;
    eName = nm;
    if (doFlush) begin
      eStage = '0;                                   // Empty request reaches M
      eStage.valid = 1'b1;
    end else begin
      eStage = refModel(r);
    end
  endtask

  // Idle requests until the last real one has been checked at W
  task automatic drain();
    repeat (3) issue('0, "idle");
  endtask

  task automatic finishTest(string nm);
    drain();
    testCount++;
    if (errCount != testErrs) failTests++;
    $display("test %-10s %s, %0d errors", nm, (errCount == testErrs) ? "ok" : "bad",
      errCount - testErrs);
    testErrs = errCount;
  endtask

  // Holds stall with a new request waiting in E
  task automatic stallHold(lsuPkg::memReq_t r, string nm, int cycles);
    @(posedge clk);
    #1;
    stall  = 1'b1;
    reqE   = r;
    eName  = nm;
    eStage = refModel(r);
    repeat (cycles) @(negedge clk);
    checkData({nm, " held"}, wStage.data, readDataW);
    checkSquash({nm, " held"}, wStage.squash, squashScW);
    checkFaults({nm, " held"}, mStage.faults, faultsM);
    @(posedge clk);
    #1;
    stall = 1'b0;
  endtask

  task automatic randomPairs(string nm);
    int a, s1, s2;
    for (int i = 0; i < RAND_PAIRS; i++) begin
      a  = $unsigned($random(seed)) % (4*`LSU_DTIM_WORDS);
      s1 = $unsigned($random(seed)) % 3;             // Store sizes byte, half, word
      s2 = $unsigned($random(seed)) % 5;
      a  = a - (a % sizeBytes(sizeFromIndex(s1)));
      issue(makeReq(lsuPkg::rwWrite, sizeFromIndex(s1), isaPkg::amoAdd, 1'b0, a,
        $random(seed)), {nm, " store"});
      a  = a - (a % sizeBytes(sizeFromIndex(s2)));
      issue(makeReq(lsuPkg::rwRead, sizeFromIndex(s2), isaPkg::amoAdd, 1'b0, a, 0),
        {nm, " load"});
    end
  endtask

  initial begin
    isaPkg::amoOp_e ops [9];
    int a;
    ops = '{isaPkg::amoAdd, isaPkg::amoSwap, isaPkg::amoXor, isaPkg::amoOr, isaPkg::amoAnd,
      isaPkg::amoMin, isaPkg::amoMax, isaPkg::amoMinu, isaPkg::amoMaxu};
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    checkData("reset", '0, readDataW);
    checkSquash("reset", 1'b0, squashScW);
    checkFaults("reset", '0, faultsM);
    for (int i = 0; i < `LSU_DTIM_WORDS; i++) begin  // Fill from the full word index
      issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 4*i,
        {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3 + 8'(i)}), "fill");
    end
    finishTest("fill");
    randomPairs("rand_le");
    finishTest("rand_le");
    bigEndian = 1'b1;
    randomPairs("rand_be");
    finishTest("rand_be");
    for (int r = 0; r < AMO_ROUNDS; r++) begin
      bigEndian = r[0];                              // Middle round in big-endian
      foreach (ops[k]) begin
        a = 4 * ($unsigned($random(seed)) % `LSU_DTIM_WORDS);
        issue(makeReq(lsuPkg::rwAmo, isaPkg::sizeWord, ops[k], 1'b1, a, $random(seed)),
          "amo");
        issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, a, 0),
          "amo load");
      end
      drain();
    end
    bigEndian = 1'b0;
    finishTest("amo");
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoLr, 1'b1, 40, 0), "lr");
    issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoSc, 1'b1, 40, 32'h1234_5678),
      "sc ok");
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 40, 0), "sc load");
    issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoSc, 1'b1, 40, 32'hdead_0001),
      "sc again");
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoLr, 1'b1, 40, 0), "lr 2");
    issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoSc, 1'b1, 80, 32'hdead_0002),
      "sc other");
    issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoSc, 1'b1, 40, 32'hdead_0003),
      "sc no res");
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 40, 0), "sc load");
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 80, 0), "sc load");
    finishTest("lrsc");
    for (int off = 1; off < 4; off++) begin
      issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 60 + off, 0),
        "mis lw");
      issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 60 + off, -1),
        "mis sw");
      issue(makeReq(lsuPkg::rwAmo, isaPkg::sizeWord, isaPkg::amoOr, 1'b1, 60 + off, -1),
        "mis amo");
      if (off[0]) begin
        issue(makeReq(lsuPkg::rwRead, isaPkg::sizeHalf, isaPkg::amoAdd, 1'b0, 60 + off, 0),
          "mis lh");
        issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeHalf, isaPkg::amoAdd, 1'b0, 60 + off, -1),
          "mis sh");
      end
    end
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 60, 0), "mis load");
    finishTest("misaligned");
    issue(makeReq(lsuPkg::rwWrite, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 100, 32'h0bad_f00d),
      "flushed", 1'b1);
    issue(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 100, 0), "fl load");
    // AMO sits in M during the stall, a repeated write would add the operand again
    issue(makeReq(lsuPkg::rwAmo, isaPkg::sizeWord, isaPkg::amoAdd, 1'b1, 100, 32'h600d_cafe),
      "amo stall");
    stallHold(makeReq(lsuPkg::rwRead, isaPkg::sizeWord, isaPkg::amoAdd, 1'b0, 100, 0),
      "ld stall", 5);
    finishTest("flushstall");
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", testCount, failTests,
      checkCount, errCount);
    if (errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+common
common/isaPkg.sv
common/lsuPkg.sv
hdl/amoAlu.sv
hdl/dtim.sv
subword/storeFormat.sv
subword/loadExtract.sv
hdl/lsuCtrl.sv
hdl/lsu.sv
verification/lsu_checker.sv
verification/tb_lsu.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_lsu
FLIST = flist.f
SIM   = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./$(SIM)); echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
